/* bcd_field_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module bcd_field_reg import rtc_edit_pkg::*; #(
  parameter bcd_t max_value = 8'h99
) (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  bcd_t load_value,
  input  logic inc,
  input  logic dec,
  output bcd_t value
);

  bcd_t inc_value;
  bcd_t dec_value;
  logic at_max;
  logic at_zero;

  // --------------------
  // digit arithmetic
  // --------------------

  // low digit 9 -> +7 gives the carry into the tens digit
  always_comb begin
    if (value[3:0] == 4'h9) begin
      inc_value = value + 8'd7;
    end else begin
      inc_value = value + 8'd1;
    end
  end

  // low digit 0 -> -7 borrows from the tens digit
  always_comb begin
    if (value[3:0] == 4'h0) begin
      dec_value = value - 8'd7;
    end else begin
      dec_value = value - 8'd1;
    end
  end

  // bcd order matches binary order, so a plain compare works
  assign at_max  = (value >= max_value);
  assign at_zero = (value == 8'h00);

  // --------------------
  // register
  // --------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      value <= 8'h00;
    end else if (load) begin
      value <= load_value;               // snapshot wins over a step
    end else if (inc) begin
      if (!at_max) begin
        value <= inc_value;
      end
    end else if (dec) begin
      if (!at_zero) begin
        value <= dec_value;
      end
    end
  end

endmodule

`default_nettype wire

/* edit_cursor.sv */
`timescale 1ns/1ps
`default_nettype none

module edit_cursor import rtc_edit_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       edit_mode,
  input  logic       up,
  input  logic       down,
  input  logic       left,
  input  logic       right,
  output field_idx_t field_sel,
  output logic       step_up,
  output logic       step_down,
  output logic [7:0] address
);

  typedef enum logic [2:0] {
    ACT_NONE,
    ACT_UP,
    ACT_DOWN,
    ACT_LEFT,
    ACT_RIGHT
  } action_t;

  action_t    action;
  field_idx_t sel_next;

  // --------------------
  // button decode
  // --------------------

  // exactly one button pressed, otherwise nothing happens
  always_comb begin
    action = ACT_NONE;
    if (edit_mode) begin
      case ({up, down, left, right})
        4'b1000: action = ACT_UP;
        4'b0100: action = ACT_DOWN;
        4'b0010: action = ACT_LEFT;
        4'b0001: action = ACT_RIGHT;
        default: action = ACT_NONE;        // idle or chord
      endcase
    end
  end

  // --------------------
  // cursor
  // --------------------

  always_comb begin
    sel_next = field_sel;
    if (!edit_mode) begin
      sel_next = FLD_SECONDS;              // park when editing ends
    end else begin
      case (action)
        ACT_RIGHT: begin
          if (field_sel == FLD_WEEKDAY) begin
            sel_next = FLD_SECONDS;        // wrap forward
          end else begin
            sel_next = field_sel + 3'd1;
          end
        end
        ACT_LEFT: begin
          if (field_sel == FLD_SECONDS) begin
            sel_next = FLD_WEEKDAY;        // wrap backward
          end else begin
            sel_next = field_sel - 3'd1;
          end
        end
        default: sel_next = field_sel;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      field_sel <= FLD_SECONDS;
    end else begin
      field_sel <= sel_next;
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign step_up   = (action == ACT_UP);
  assign step_down = (action == ACT_DOWN);

  always_comb begin
    if (edit_mode) begin
      address = FIELD_ADDR[field_sel];     // register of the field on screen
    end else begin
      address = IDLE_ADDR;
    end
  end

endmodule

`default_nettype wire

/* field_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module field_bank import rtc_edit_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       snapshot_load,
  input  logic       edit_mode,
  input  bcd_t       rtc_seconds,
  input  bcd_t       rtc_minutes,
  input  bcd_t       rtc_hours,
  input  bcd_t       rtc_date,
  input  bcd_t       rtc_month,
  input  bcd_t       rtc_year,
  input  bcd_t       rtc_weekday,
  input  field_idx_t field_sel,
  input  logic       step_up,
  input  logic       step_down,
  output bcd_t       data_mod,
  output bcd_t       seconds,
  output bcd_t       minutes,
  output bcd_t       hours,
  output bcd_t       date,
  output bcd_t       month,
  output bcd_t       year,
  output bcd_t       weekday
);

  bcd_t load_bus    [NUM_FIELDS];
  bcd_t field_value [NUM_FIELDS];

  // chip snapshot, one byte per field
  assign load_bus[FLD_SECONDS] = rtc_seconds;
  assign load_bus[FLD_MINUTES] = rtc_minutes;
  assign load_bus[FLD_HOURS]   = rtc_hours;
  assign load_bus[FLD_DATE]    = rtc_date;
  assign load_bus[FLD_MONTH]   = rtc_month;
  assign load_bus[FLD_YEAR]    = rtc_year;
  assign load_bus[FLD_WEEKDAY] = rtc_weekday;

  // --------------------
  // field registers
  // --------------------

  for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_field
    logic sel_hit;

    assign sel_hit = (field_sel == field_idx_t'(i));  // only the cursor field steps

    bcd_field_reg #(
      .max_value (FIELD_MAX[i])
    ) u_reg (
      .clk        (clk),
      .reset      (reset),
      .load       (snapshot_load),
      .load_value (load_bus[i]),
      .inc        (step_up && sel_hit),
      .dec        (step_down && sel_hit),
      .value      (field_value[i])
    );
  end

  // write-back byte for the chip
  assign data_mod = edit_mode ? field_value[field_sel] : 8'h00;

  assign seconds = field_value[FLD_SECONDS];
  assign minutes = field_value[FLD_MINUTES];
  assign hours   = field_value[FLD_HOURS];
  assign date    = field_value[FLD_DATE];
  assign month   = field_value[FLD_MONTH];
  assign year    = field_value[FLD_YEAR];
  assign weekday = field_value[FLD_WEEKDAY];

endmodule

`default_nettype wire

/* field_bank_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module field_bank_checker import rtc_edit_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       step_up,
  input logic       step_down,
  input field_idx_t field_sel,
  input bcd_t       seconds,
  input bcd_t       minutes,
  input bcd_t       hours,
  input bcd_t       date,
  input bcd_t       month,
  input bcd_t       year,
  input bcd_t       weekday
);

  bcd_t fields [NUM_FIELDS];

  assign fields[0] = seconds;
  assign fields[1] = minutes;
  assign fields[2] = hours;
  assign fields[3] = date;
  assign fields[4] = month;
  assign fields[5] = year;
  assign fields[6] = weekday;

  // --------------------
  // strobes and cursor
  // --------------------

  a_one_step: assert property (@(posedge clk) disable iff (reset) !(step_up && step_down))
    else $error("step_up and step_down are high together");

  a_sel_range: assert property (@(posedge clk) disable iff (reset)
    int'(field_sel) < NUM_FIELDS)
    else $error("field_sel points past the last field");

  // digits stay 0..9 and the byte stays under its limit
  for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_field
    a_valid: assert property (@(posedge clk) disable iff (reset)
      fields[i][7:4] <= 4'h9 && fields[i][3:0] <= 4'h9 && fields[i] <= FIELD_MAX[i])
      else $error("field %0d holds %02h, not valid bcd within range", i, fields[i]);
  end

endmodule

bind field_bank field_bank_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .step_up   (step_up),
  .step_down (step_down),
  .field_sel (field_sel),
  .seconds   (seconds),
  .minutes   (minutes),
  .hours     (hours),
  .date      (date),
  .month     (month),
  .year      (year),
  .weekday   (weekday)
);

`default_nettype wire

/* files.f */
rtc_edit_pkg.sv
edit_cursor.sv
bcd_field_reg.sv
field_bank.sv
rtc_time_editor.sv
field_bank_checker.sv
tb_rtc_time_editor.sv

/* rtc_edit_pkg.sv */
`default_nettype none

package rtc_edit_pkg;

  // --------------------
  // field layout
  // --------------------

  localparam int NUM_FIELDS = 7;             // seconds .. weekday

  typedef logic [2:0] field_idx_t;           // selects one field
  typedef logic [7:0] bcd_t;                 // two packed bcd digits

  // field indices, in cursor order
  localparam field_idx_t FLD_SECONDS = 3'd0;
  localparam field_idx_t FLD_MINUTES = 3'd1;
  localparam field_idx_t FLD_HOURS   = 3'd2;
  localparam field_idx_t FLD_DATE    = 3'd3;
  localparam field_idx_t FLD_MONTH   = 3'd4;
  localparam field_idx_t FLD_YEAR    = 3'd5;
  localparam field_idx_t FLD_WEEKDAY = 3'd6;

  // --------------------
  // clock chip registers
  // --------------------

  localparam logic [7:0] IDLE_ADDR = 8'h00;  // nothing selected

  localparam logic [0:NUM_FIELDS-1][7:0] FIELD_ADDR = '{
    8'h21,                                   // seconds
    8'h22,                                   // minutes
    8'h23,                                   // hours
    8'h24,                                   // date
    8'h25,                                   // month
    8'h26,                                   // year
    8'h27                                    // weekday
  };

  // upper limit of each field, in bcd
  localparam bcd_t [0:NUM_FIELDS-1] FIELD_MAX = '{
    8'h59,                                   // seconds
    8'h59,                                   // minutes
    8'h23,                                   // hours, 24h format
    8'h31,                                   // date
    8'h12,                                   // month
    8'h99,                                   // year
    8'h07                                    // weekday
  };

endpackage

`default_nettype wire

/* rtc_time_editor.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_time_editor import rtc_edit_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       edit_mode,
  input  logic       up,
  input  logic       down,
  input  logic       left,
  input  logic       right,
  input  logic       snapshot_load,
  input  bcd_t       rtc_seconds,
  input  bcd_t       rtc_minutes,
  input  bcd_t       rtc_hours,
  input  bcd_t       rtc_date,
  input  bcd_t       rtc_month,
  input  bcd_t       rtc_year,
  input  bcd_t       rtc_weekday,
  output logic [7:0] address,
  output bcd_t       data_mod,
  output bcd_t       seconds,
  output bcd_t       minutes,
  output bcd_t       hours,
  output bcd_t       date,
  output bcd_t       month,
  output bcd_t       year,
  output bcd_t       weekday
);

  field_idx_t field_sel;
  logic       step_up;
  logic       step_down;

  // --------------------
  // button decode and cursor
  // --------------------

  edit_cursor u_cursor (
    .clk       (clk),
    .reset     (reset),
    .edit_mode (edit_mode),
    .up        (up),
    .down      (down),
    .left      (left),
    .right     (right),
    .field_sel (field_sel),
    .step_up   (step_up),
    .step_down (step_down),
    .address   (address)
  );

  // --------------------
  // time and date registers
  // --------------------

  field_bank u_bank (
    .clk           (clk),
    .reset         (reset),
    .snapshot_load (snapshot_load),
    .edit_mode     (edit_mode),
    .rtc_seconds   (rtc_seconds),
    .rtc_minutes   (rtc_minutes),
    .rtc_hours     (rtc_hours),
    .rtc_date      (rtc_date),
    .rtc_month     (rtc_month),
    .rtc_year      (rtc_year),
    .rtc_weekday   (rtc_weekday),
    .field_sel     (field_sel),
    .step_up       (step_up),
    .step_down     (step_down),
    .data_mod      (data_mod),
    .seconds       (seconds),
    .minutes       (minutes),
    .hours         (hours),
    .date          (date),
    .month         (month),
    .year          (year),
    .weekday       (weekday)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the rtc field editor testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_rtc_time_editor \
  || { echo "run.sh: build failed"; exit 1; }
result=$(./obj_dir/Vtb_rtc_time_editor)
echo "$result"
echo "$result" | grep -qx "TESTBENCH PASSED" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation did not pass"; exit 1; }

/* tb_rtc_time_editor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rtc_time_editor import rtc_edit_pkg::*; ();

  localparam int CLK_PERIOD    = 8;
  localparam int RANDOM_CYCLES = 2000;
  localparam int STEP_CYCLES   = 700;   // up and down sweeps over all fields
  localparam int OTHER_CYCLES  = 120;   // reset, loads, cursor walk, chords
  localparam int MARGIN_CYCLES = 200;
  localparam int WATCHDOG_NS   = (RANDOM_CYCLES + STEP_CYCLES + OTHER_CYCLES + MARGIN_CYCLES)
                                 * CLK_PERIOD;

  logic       clk;
  logic       reset;
  logic       edit_mode;
  logic       up;
  logic       down;
  logic       left;
  logic       right;
  logic       snapshot_load;
  bcd_t       rtc_in [NUM_FIELDS];
  logic [7:0] address;
  bcd_t       data_mod;
  bcd_t       dut_field [NUM_FIELDS];

  bcd_t        m_field [NUM_FIELDS];  // reference copy of the bank
  field_idx_t  m_sel;                 // reference cursor
  logic [15:0] lfsr;
  int          errors;
  int          checks;

  rtc_time_editor UUT (
    .clk           (clk),
    .reset         (reset),
    .edit_mode     (edit_mode),
    .up            (up),
    .down          (down),
    .left          (left),
    .right         (right),
    .snapshot_load (snapshot_load),
    .rtc_seconds   (rtc_in[0]),
    .rtc_minutes   (rtc_in[1]),
    .rtc_hours     (rtc_in[2]),
    .rtc_date      (rtc_in[3]),
    .rtc_month     (rtc_in[4]),
    .rtc_year      (rtc_in[5]),
    .rtc_weekday   (rtc_in[6]),
    .address       (address),
    .data_mod      (data_mod),
    .seconds       (dut_field[0]),
    .minutes       (dut_field[1]),
    .hours         (dut_field[2]),
    .date          (dut_field[3]),
    .month         (dut_field[4]),
    .year          (dut_field[5]),
    .weekday       (dut_field[6])
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------
  // helpers
  // --------------------

  // taps of x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[14:0], fb};
    end
    return r;
  endfunction

  function automatic int bcd_to_int(input bcd_t v);
    return int'(v[7:4]) * 10 + int'(v[3:0]);
  endfunction

  function automatic bcd_t int_to_bcd(input int d);
    return bcd_t'((d / 10) * 16 + (d % 10));
  endfunction

  function automatic bcd_t rand_bcd(input bcd_t limit);
    int d;
    d = int'(rand_bits(8)) % (bcd_to_int(limit) + 1);
    return int_to_bcd(d);
  endfunction

  function automatic bcd_t bcd_plus_one(input bcd_t v, input bcd_t limit);
    if (v == limit) begin
      return v;                       // saturate at the top
    end
    return int_to_bcd(bcd_to_int(v) + 1);
  endfunction

  function automatic bcd_t bcd_minus_one(input bcd_t v);
    if (v == 8'h00) begin
      return v;
    end
    return int_to_bcd(bcd_to_int(v) - 1);
  endfunction

  task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_value(address, edit_mode ? FIELD_ADDR[m_sel] : IDLE_ADDR, "address");
    check_value(data_mod, edit_mode ? m_field[m_sel] : 8'h00, "data_mod");
    for (int i = 0; i < NUM_FIELDS; i++) begin
      check_value(dut_field[i], m_field[i], $sformatf("field %0d", i));
    end
  endtask

  // reference update on a rising edge while the inputs are held
  task automatic model_edge();
    int pressed;
    pressed = int'(up) + int'(down) + int'(left) + int'(right);
    if (snapshot_load) begin
      for (int i = 0; i < NUM_FIELDS; i++) begin
        m_field[i] = rtc_in[i];
      end
    end else if (edit_mode && pressed == 1 && up) begin
      m_field[m_sel] = bcd_plus_one(m_field[m_sel], FIELD_MAX[m_sel]);
    end else if (edit_mode && pressed == 1 && down) begin
      m_field[m_sel] = bcd_minus_one(m_field[m_sel]);
    end
    if (!edit_mode) begin
      m_sel = FLD_SECONDS;
    end else if (pressed == 1 && right) begin
      m_sel = (m_sel == FLD_WEEKDAY) ? FLD_SECONDS : m_sel + 3'd1;
    end else if (pressed == 1 && left) begin
      m_sel = (m_sel == FLD_SECONDS) ? FLD_WEEKDAY : m_sel - 3'd1;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    model_edge();
    #1;                               // let the outputs settle
    check_outputs();
  endtask

  task automatic release_buttons();
    up    = 1'b0;
    down  = 1'b0;
    left  = 1'b0;
    right = 1'b0;
  endtask

  task automatic load_random(input logic with_step);
    for (int i = 0; i < NUM_FIELDS; i++) begin
      rtc_in[i] = rand_bcd(FIELD_MAX[i]);
    end
    snapshot_load = 1'b1;
    up            = with_step;        // step must lose against the load
    tick();
    snapshot_load = 1'b0;
    release_buttons();
  endtask

  task automatic move_cursor_to(input field_idx_t f);
    while (m_sel != f) begin
      right = 1'b1;
      tick();
    end
    right = 1'b0;
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", num, name, errors - errs_before);
  endtask

  // --------------------
  // tests
  // --------------------

  initial begin
    int         mark;
    int         hold;
    logic [3:0] combo;
    errors        = 0;
    checks        = 0;
    lfsr          = 16'd7524;
    reset         = 1'b1;
    edit_mode     = 1'b0;
    snapshot_load = 1'b0;
    release_buttons();
    for (int i = 0; i < NUM_FIELDS; i++) begin
      rtc_in[i]  = 8'h00;
      m_field[i] = 8'h00;
    end
    m_sel = FLD_SECONDS;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;

    mark = errors;
    check_outputs();                  // idle outputs straight after reset
    edit_mode = 1'b1;
    tick();
    check_value(address, 8'h21, "address in edit mode");
    end_test(1, "reset state", mark);

    mark = errors;
    for (int n = 0; n < 4; n++) begin
      load_random(1'b1);
      tick();
    end
    end_test(2, "snapshot load", mark);

    mark = errors;
    for (int f = 0; f < NUM_FIELDS; f++) begin
      move_cursor_to(field_idx_t'(f));
      for (int i = 0; i < NUM_FIELDS; i++) begin
        rtc_in[i] = 8'h00;
      end
      snapshot_load = 1'b1;
      tick();
      snapshot_load = 1'b0;
      hold = bcd_to_int(FIELD_MAX[f]) + 2;  // walk past the top
      up   = 1'b1;
      repeat (hold) tick();
      up   = 1'b0;
      down = 1'b1;
      repeat (hold) tick();
      down = 1'b0;
    end
    end_test(3, "bcd up and down", mark);

    mark = errors;
    move_cursor_to(FLD_SECONDS);
    right = 1'b1;
    repeat (NUM_FIELDS) tick();
    right = 1'b0;
    check_value(address, 8'h21, "address after right wrap");
    left = 1'b1;
    repeat (NUM_FIELDS) tick();
    left = 1'b0;
    check_value(address, 8'h21, "address after left wrap");
    end_test(4, "cursor wrap", mark);

    mark = errors;
    load_random(1'b0);
    move_cursor_to(FLD_DATE);
    for (int c = 0; c < 16; c++) begin
      combo = 4'(c);
      if ($countones(combo) >= 2) begin
        {up, down, left, right} = combo;
        tick();
      end
    end
    edit_mode = 1'b0;
    for (int n = 0; n < 8; n++) begin
      {up, down, left, right} = 4'(rand_bits(4));
      tick();
    end
    release_buttons();
    edit_mode = 1'b1;
    tick();
    check_value(address, 8'h21, "address after edit mode comes back");
    end_test(5, "chords and edit mode off", mark);

    mark = errors;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      edit_mode     = (rand_bits(3) != '0);
      up            = (rand_bits(2) == '0);
      down          = (rand_bits(2) == '0);
      left          = (rand_bits(2) == '0);
      right         = (rand_bits(2) == '0);
      snapshot_load = (rand_bits(5) == '0);  // rare reload
      for (int i = 0; i < NUM_FIELDS; i++) begin
        rtc_in[i] = rand_bcd(FIELD_MAX[i]);
      end
      tick();
    end
    snapshot_load = 1'b0;
    release_buttons();
    end_test(6, "random run", mark);

    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
